/* core.f */
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core.sv
dv/core_checker.sv
dv/core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = core.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

  localparam int PROG_LEN = 28;

  logic        clk_i;
  logic        reset_i;
  logic        stall_i;
  logic        rom_en_o;
  logic [31:0] rom_addr_o;
  logic [31:0] rom_data_i;
  logic        ram_en_o;
  logic        ram_we_o;
  logic [31:0] ram_addr_o;
  logic [31:0] ram_wdata_o;
  logic [31:0] ram_rdata_i;
  logic        debug_reg_we_o;
  logic [4:0]  debug_reg_addr_o;
  logic [31:0] debug_reg_data_o;
  logic [31:0] debug_pc_o;
  logic [31:0] rom [64];
  logic [31:0] ram [64];
  logic        done;
  int          errors;
  int          reg_left;
  int          store_left;
  int          seed = 32'ha6ab;

  core u_dut (.*);

  core_checker u_checker (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .stall_i          (stall_i),
    .rom_i            (rom),
    .rom_en_i         (rom_en_o),
    .ram_en_i         (ram_en_o),
    .debug_reg_we_i   (debug_reg_we_o),
    .debug_reg_addr_i (debug_reg_addr_o),
    .debug_reg_data_i (debug_reg_data_o),
    .debug_pc_i       (debug_pc_o),
    .ram_we_i         (ram_we_o),
    .ram_addr_i       (ram_addr_o),
    .ram_wdata_i      (ram_wdata_o),
    .done_o           (done),
    .errors_o         (errors),
    .reg_left_o       (reg_left),
    .store_left_o     (store_left)
  );

  // Both memories answer in the same cycle, inverted data while not enabled
  assign rom_data_i  = rom_en_o ? rom[rom_addr_o[7:2]] : ~rom[rom_addr_o[7:2]];
  assign ram_rdata_i = ram_en_o ? ram[ram_addr_o[7:2]] : ~ram[ram_addr_o[7:2]];

  always @(posedge clk_i) begin
    if (ram_we_o) ram[ram_addr_o[7:2]] <= ram_wdata_o;
  end

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] r_type(core_pkg::funct_e fn, logic [4:0] rs,
                                         logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] i_type(core_pkg::opcode_e op, logic [4:0] rs,
                                         logic [4:0] rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic build_program();
    logic [15:0] off_a;
    logic [15:0] off_b;
    logic [15:0] off_c;
    off_a = 16'($random(seed)) & 16'h00fc;
    off_b = 16'($random(seed)) & 16'h00fc;
    off_c = 16'($random(seed)) & 16'h00fc;
    foreach (rom[i]) rom[i] = '0;
    foreach (ram[i]) ram[i] = 32'(i) * 32'h9e37_79b9;
    rom[0]  = i_type(core_pkg::OP_ADDIU, 5'd0, 5'd1, 16'($random(seed)));
    rom[1]  = i_type(core_pkg::OP_ORI, 5'd0, 5'd2, 16'($random(seed)));
    rom[2]  = r_type(core_pkg::FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0);
    rom[3]  = r_type(core_pkg::FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0);
    rom[4]  = i_type(core_pkg::OP_LUI, 5'd0, 5'd5, 16'($random(seed)));
    rom[5]  = r_type(core_pkg::FN_AND, 5'd5, 5'd3, 5'd6, 5'd0);
    rom[6]  = r_type(core_pkg::FN_OR, 5'd4, 5'd2, 5'd7, 5'd0);
    rom[7]  = r_type(core_pkg::FN_XOR, 5'd7, 5'd6, 5'd8, 5'd0);
    rom[8]  = r_type(core_pkg::FN_SLT, 5'd4, 5'd3, 5'd9, 5'd0);
    rom[9]  = r_type(core_pkg::FN_SLL, 5'd0, 5'd8, 5'd10, 5'd5);
    rom[10] = i_type(core_pkg::OP_SW, 5'd0, 5'd8, off_a);
    rom[11] = i_type(core_pkg::OP_SW, 5'd0, 5'd10, off_b);
    // Load followed by its consumer
    rom[12] = i_type(core_pkg::OP_LW, 5'd0, 5'd11, off_a);
    rom[13] = r_type(core_pkg::FN_ADDU, 5'd11, 5'd1, 5'd12, 5'd0);
    rom[14] = i_type(core_pkg::OP_LW, 5'd0, 5'd13, off_b);
    rom[15] = i_type(core_pkg::OP_SW, 5'd0, 5'd13, off_c);
    // Taken BEQ skips word 18, then a BNE that falls through
    rom[16] = i_type(core_pkg::OP_BEQ, 5'd1, 5'd1, 16'd2);
    rom[17] = i_type(core_pkg::OP_ADDIU, 5'd0, 5'd14, 16'($random(seed)));
    rom[18] = i_type(core_pkg::OP_ADDIU, 5'd0, 5'd15, 16'd1);
    rom[19] = i_type(core_pkg::OP_BNE, 5'd1, 5'd1, 16'd5);
    rom[20] = i_type(core_pkg::OP_ADDIU, 5'd14, 5'd16, 16'd3);
    rom[21] = r_type(core_pkg::FN_SLT, 5'd2, 5'd1, 5'd17, 5'd0);
    // Loaded value decides whether word 25 is skipped
    rom[22] = i_type(core_pkg::OP_LW, 5'd0, 5'd18, off_c);
    rom[23] = i_type(core_pkg::OP_BNE, 5'd18, 5'd0, 16'd2);
    rom[24] = r_type(core_pkg::FN_XOR, 5'd18, 5'd1, 5'd19, 5'd0);
    rom[25] = r_type(core_pkg::FN_ADDU, 5'd19, 5'd18, 5'd20, 5'd0);
    rom[26] = i_type(core_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff);
  endtask

  task automatic print_counts();
    $display("Summary: %0d errors, %0d register writes missing, %0d stores missing",
             errors, reg_left, store_left);
  endtask

  initial begin : stall_gen
    int run_left;
    run_left = 0;
    stall_i  = 1'b0;
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      if (run_left > 0) begin
        stall_i = 1'b1;
        run_left--;
      end else if (($random(seed) & 7) == 0) begin
        stall_i  = 1'b1;
        run_left = $random(seed) & 3;
      end else begin
        stall_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int   cycles;
    int   stall_cycles;
    logic expired;
    cycles       = 0;
    stall_cycles = 0;
    expired      = 1'b0;
    @(negedge reset_i);
    while (!done && !expired) begin
      @(posedge clk_i);
      cycles++;
      if (stall_i) stall_cycles++;
      expired = cycles > 4 * PROG_LEN + stall_cycles + 50;
    end
    if (expired) begin
      $display("Watchdog timeout after %0d cycles, expected events never all appeared",
               cycles);
      print_counts();
      $display("Regression failed");
      $finish;
    end
  end

  initial begin : main
    reset_i = 1'b1;
    build_program();
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    wait (done);
    // Drain so that extra writes are caught
    repeat (20) @(posedge clk_i);
    print_counts();
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* dv/core_checker.sv */
`timescale 1ns/1ps

module core_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        stall_i,
  input  logic [31:0] rom_i [64],
  input  logic        rom_en_i,
  input  logic        ram_en_i,
  input  logic        debug_reg_we_i,
  input  logic [4:0]  debug_reg_addr_i,
  input  logic [31:0] debug_reg_data_i,
  input  logic [31:0] debug_pc_i,
  input  logic        ram_we_i,
  input  logic [31:0] ram_addr_i,
  input  logic [31:0] ram_wdata_i,
  output logic        done_o,
  output int          errors_o,
  output int          reg_left_o,
  output int          store_left_o
);

  // Self-branch that ends every program
  localparam logic [31:0] HALT_WORD = 32'h1000_ffff;

  typedef struct packed {
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] pc;
  } reg_event_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_event_t;

  reg_event_t   exp_regs [$];
  store_event_t exp_stores [$];
  logic [31:0]  m_regs [32];
  logic [31:0]  m_mem [64];
  logic [31:0]  m_pc;
  logic [31:0]  m_npc;
  int           reg_idx = 0;
  int           store_idx = 0;
  int           n_reg = 0;
  int           n_store = 0;
  int           errors = 0;
  logic         built = 1'b0;
  logic         fresh = 1'b0;
  logic         was_reset = 1'b0;

  // Architectural step with one delay slot
  function automatic void step_model(logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] cur_pc;
    logic [4:0]  dest;
    logic        wr;
    a      = m_regs[inst[25:21]];
    b      = m_regs[inst[20:16]];
    simm   = {{16{inst[15]}}, inst[15:0]};
    cur_pc = m_pc;
    m_pc   = m_npc;
    m_npc  = m_npc + 32'd4;
    wr     = 1'b1;
    dest   = inst[20:16];
    res    = '0;
    addr   = a + simm;
    case (inst[31:26])
      6'h00: begin
        dest = inst[15:11];
        case (inst[5:0])
          6'h21: res = a + b;
          6'h23: res = a - b;
          6'h24: res = a & b;
          6'h25: res = a | b;
          6'h26: res = a ^ b;
          6'h2a: res = {31'b0, $signed(a) < $signed(b)};
          6'h00: res = b << inst[10:6];
          default: wr = 1'b0;
        endcase
      end
      6'h09: res = a + simm;
      6'h0d: res = a | {16'h0000, inst[15:0]};
      6'h0f: res = {inst[15:0], 16'h0000};
      6'h23: res = m_mem[addr[7:2]];
      6'h2b: begin
        wr = 1'b0;
        m_mem[addr[7:2]] = b;
        exp_stores.push_back('{addr: addr, data: b});
      end
      6'h04, 6'h05: begin
        wr = 1'b0;
        if ((a == b) == (inst[31:26] == 6'h04)) begin
          m_npc = cur_pc + 32'd4 + {simm[29:0], 2'b00};
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && dest != 5'd0) begin
      m_regs[dest] = res;
      exp_regs.push_back('{addr: dest, data: res, pc: cur_pc});
    end
  endfunction

  task automatic run_model();
    int steps;
    steps = 0;
    foreach (m_regs[i]) m_regs[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    m_pc  = 32'h0;
    m_npc = 32'h4;
    while (rom_i[m_pc[7:2]] != HALT_WORD && steps < 200) begin
      step_model(rom_i[m_pc[7:2]]);
      steps++;
    end
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
    $display("FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
    errors++;
  endtask

  task automatic check_reg_write();
    reg_event_t want;
    if (reg_idx >= n_reg) begin
      $display("Unexpected extra register write to r%0d at pc %h", debug_reg_addr_i,
               debug_pc_i);
      errors++;
    end else begin
      want = exp_regs[reg_idx];
      reg_idx++;
      if (debug_reg_addr_i !== want.addr)
        report_mismatch("debug_reg_addr_o", 32'(debug_reg_addr_i), 32'(want.addr));
      if (debug_reg_data_i !== want.data)
        report_mismatch("debug_reg_data_o", debug_reg_data_i, want.data);
      if (debug_pc_i !== want.pc)
        report_mismatch("debug_pc_o", debug_pc_i, want.pc);
    end
  endtask

  task automatic check_store();
    store_event_t want;
    if (store_idx >= n_store) begin
      $display("Unexpected extra store to address %h", ram_addr_i);
      errors++;
    end else begin
      want = exp_stores[store_idx];
      store_idx++;
      if (ram_addr_i !== want.addr) report_mismatch("ram_addr_o", ram_addr_i, want.addr);
      if (ram_wdata_i !== want.data) report_mismatch("ram_wdata_o", ram_wdata_i, want.data);
    end
  endtask

  initial begin
    @(negedge reset_i);
    run_model();
    n_reg   = exp_regs.size();
    n_store = exp_stores.size();
    built   = 1'b1;
  end

  // Outputs only count once after the register behind them was loaded
  always @(posedge clk_i) begin
    if (was_reset && (rom_en_i || ram_en_i || ram_we_i || debug_reg_we_i)) begin
      $display("Enable output found high right after a reset cycle at %0t", $time);
      errors++;
    end
    if (fresh && debug_reg_we_i) check_reg_write();
    if (fresh && ram_we_i) check_store();
    fresh     = !stall_i && !reset_i;
    was_reset = reset_i;
  end

  assign done_o       = built && reg_idx == n_reg && store_idx == n_store;
  assign errors_o     = errors;
  assign reg_left_o   = n_reg - reg_idx;
  assign store_left_o = n_store - store_idx;

endmodule

/* hw/core.sv */
`timescale 1ns/1ps

module core (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 stall_i,
  output logic                 rom_en_o,
  output core_pkg::data_t      rom_addr_o,
  input  core_pkg::data_t      rom_data_i,
  output logic                 ram_en_o,
  output logic                 ram_we_o,
  output core_pkg::data_t      ram_addr_o,
  output core_pkg::data_t      ram_wdata_o,
  input  core_pkg::data_t      ram_rdata_i,
  output logic                 debug_reg_we_o,
  output core_pkg::reg_addr_t  debug_reg_addr_o,
  output core_pkg::data_t      debug_reg_data_o,
  output core_pkg::data_t      debug_pc_o
);

  core_pkg::if_id_t    if_id;
  core_pkg::id_ex_t    id_ex;
  core_pkg::ex_mem_t   ex_mem;
  core_pkg::wb_write_t wb;
  core_pkg::fwd_src_t  ex_fwd;
  core_pkg::fwd_src_t  mem_fwd;
  core_pkg::reg_addr_t rf_raddr_1;
  core_pkg::reg_addr_t rf_raddr_2;
  core_pkg::data_t     rf_rdata_1;
  core_pkg::data_t     rf_rdata_2;
  core_pkg::data_t     branch_target;
  logic                branch_taken;
  logic                hazard_stall;

  fetch_stage u_fetch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .freeze_i        (stall_i),
    .hazard_stall_i  (hazard_stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .rom_data_i      (rom_data_i),
    .rom_en_o        (rom_en_o),
    .rom_addr_o      (rom_addr_o),
    .if_id_o         (if_id)
  );

  decode_stage u_decode (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .freeze_i        (stall_i),
    .if_id_i         (if_id),
    .rf_rdata_1_i    (rf_rdata_1),
    .rf_rdata_2_i    (rf_rdata_2),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .rf_raddr_1_o    (rf_raddr_1),
    .rf_raddr_2_o    (rf_raddr_2),
    .hazard_stall_o  (hazard_stall),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .id_ex_o         (id_ex)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_1_i (rf_raddr_1),
    .raddr_2_i (rf_raddr_2),
    .wb_i      (wb),
    .rdata_1_o (rf_rdata_1),
    .rdata_2_o (rf_rdata_2)
  );

  execute_stage u_execute (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .freeze_i (stall_i),
    .id_ex_i  (id_ex),
    .ex_fwd_o (ex_fwd),
    .ex_mem_o (ex_mem)
  );

  memory_stage u_memory (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .freeze_i    (stall_i),
    .ex_mem_i    (ex_mem),
    .ram_rdata_i (ram_rdata_i),
    .ram_en_o    (ram_en_o),
    .ram_we_o    (ram_we_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .mem_fwd_o   (mem_fwd),
    .wb_o        (wb),
    .debug_pc_o  (debug_pc_o)
  );

  // Decode already drops r0 as a destination
  assign debug_reg_we_o   = wb.reg_write_en;
  assign debug_reg_addr_o = wb.reg_write_addr;
  assign debug_reg_data_o = wb.write_data;

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 freeze_i,
  input  core_pkg::ex_mem_t    ex_mem_i,
  input  core_pkg::data_t      ram_rdata_i,
  output logic                 ram_en_o,
  output logic                 ram_we_o,
  output core_pkg::data_t      ram_addr_o,
  output core_pkg::data_t      ram_wdata_o,
  output core_pkg::fwd_src_t   mem_fwd_o,
  output core_pkg::wb_write_t  wb_o,
  output core_pkg::data_t      debug_pc_o
);

  core_pkg::data_t     mem_value;
  core_pkg::wb_write_t wb_q;
  core_pkg::data_t     pc_q;

  assign ram_en_o    = ex_mem_i.mem_read || ex_mem_i.mem_write;
  assign ram_we_o    = ex_mem_i.mem_write;
  assign ram_addr_o  = ex_mem_i.result;
  assign ram_wdata_o = ex_mem_i.mem_write_data;

  // RAM answers in the same cycle
  assign mem_value = ex_mem_i.mem_read ? ram_rdata_i : ex_mem_i.result;

  always_comb begin
    mem_fwd_o.write_en   = ex_mem_i.reg_write_en;
    mem_fwd_o.write_addr = ex_mem_i.reg_write_addr;
    mem_fwd_o.value      = mem_value;
    mem_fwd_o.is_load    = ex_mem_i.mem_read;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_q <= '0;
      pc_q <= '0;
    end else if (!freeze_i) begin
      wb_q.reg_write_en   <= ex_mem_i.reg_write_en;
      wb_q.reg_write_addr <= ex_mem_i.reg_write_addr;
      wb_q.write_data     <= mem_value;
      pc_q                <= ex_mem_i.pc;
    end
  end

  assign wb_o       = wb_q;
  assign debug_pc_o = pc_q;

  we_implies_en_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ram_we_o |-> ram_en_o);

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 freeze_i,
  input  core_pkg::id_ex_t     id_ex_i,
  output core_pkg::fwd_src_t   ex_fwd_o,
  output core_pkg::ex_mem_t    ex_mem_o
);

  core_pkg::data_t   op_1;
  core_pkg::data_t   op_2;
  core_pkg::data_t   result;
  core_pkg::ex_mem_t ex_mem_q;

  assign op_1 = id_ex_i.operand_1;
  assign op_2 = id_ex_i.operand_2;

  // Loads and stores use ADD, so result doubles as the address
  always_comb begin
    case (id_ex_i.alu_op)
      core_pkg::ALU_ADD: result = op_1 + op_2;
      core_pkg::ALU_SUB: result = op_1 - op_2;
      core_pkg::ALU_AND: result = op_1 & op_2;
      core_pkg::ALU_OR:  result = op_1 | op_2;
      core_pkg::ALU_XOR: result = op_1 ^ op_2;
      core_pkg::ALU_SLT: result = {31'b0, $signed(op_1) < $signed(op_2)};
      core_pkg::ALU_SLL: result = op_2 << id_ex_i.shamt;
      core_pkg::ALU_LUI: result = {op_2[15:0], 16'h0000};
      default:           result = '0;
    endcase
  end

  always_comb begin
    ex_fwd_o.write_en   = id_ex_i.reg_write_en;
    ex_fwd_o.write_addr = id_ex_i.reg_write_addr;
    ex_fwd_o.value      = result;
    ex_fwd_o.is_load    = id_ex_i.mem_read;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_mem_q <= '0;
    end else if (!freeze_i) begin
      ex_mem_q.result         <= result;
      ex_mem_q.mem_read       <= id_ex_i.mem_read;
      ex_mem_q.mem_write      <= id_ex_i.mem_write;
      ex_mem_q.mem_write_data <= id_ex_i.mem_write_data;
      ex_mem_q.reg_write_en   <= id_ex_i.reg_write_en;
      ex_mem_q.reg_write_addr <= id_ex_i.reg_write_addr;
      ex_mem_q.pc             <= id_ex_i.pc;
    end
  end

  assign ex_mem_o = ex_mem_q;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  core_pkg::reg_addr_t  raddr_1_i,
  input  core_pkg::reg_addr_t  raddr_2_i,
  input  core_pkg::wb_write_t  wb_i,
  output core_pkg::data_t      rdata_1_o,
  output core_pkg::data_t      rdata_2_o
);

  core_pkg::data_t regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!reset_i && wb_i.reg_write_en && wb_i.reg_write_addr != '0) begin
      regs[wb_i.reg_write_addr] <= wb_i.write_data;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  function automatic core_pkg::data_t read_port(core_pkg::reg_addr_t addr);
    if (addr == '0) return '0;
    if (wb_i.reg_write_en && wb_i.reg_write_addr == addr) return wb_i.write_data;
    return regs[addr];
  endfunction

  always_comb begin
    rdata_1_o = read_port(raddr_1_i);
    rdata_2_o = read_port(raddr_2_i);
  end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  freeze_i,
  input  core_pkg::if_id_t      if_id_i,
  input  core_pkg::data_t       rf_rdata_1_i,
  input  core_pkg::data_t       rf_rdata_2_i,
  input  core_pkg::fwd_src_t    ex_fwd_i,
  input  core_pkg::fwd_src_t    mem_fwd_i,
  output core_pkg::reg_addr_t   rf_raddr_1_o,
  output core_pkg::reg_addr_t   rf_raddr_2_o,
  output logic                  hazard_stall_o,
  output logic                  branch_taken_o,
  output core_pkg::data_t       branch_target_o,
  output core_pkg::id_ex_t      id_ex_o
);

  core_pkg::data_t     inst;
  core_pkg::opcode_e   opcode;
  core_pkg::funct_e    funct;
  core_pkg::reg_addr_t rs;
  core_pkg::reg_addr_t rt;
  core_pkg::reg_addr_t rd;
  core_pkg::data_t     imm_sext;
  core_pkg::data_t     imm_zext;
  core_pkg::data_t     op_1;
  core_pkg::data_t     op_2;
  core_pkg::id_ex_t    dec;
  core_pkg::id_ex_t    id_ex_q;
  core_pkg::reg_addr_t wr_addr;
  logic                wr_en;
  logic                uses_rs;
  logic                uses_rt;
  logic                known_op;

  assign inst     = if_id_i.inst;
  assign opcode   = core_pkg::opcode_e'(inst[31:26]);
  assign funct    = core_pkg::funct_e'(inst[5:0]);
  assign rs       = inst[25:21];
  assign rt       = inst[20:16];
  assign rd       = inst[15:11];
  assign imm_sext = {{16{inst[15]}}, inst[15:0]};
  assign imm_zext = {16'h0000, inst[15:0]};

  assign rf_raddr_1_o = rs;
  assign rf_raddr_2_o = rt;

  // Youngest producer wins
  function automatic core_pkg::data_t pick(core_pkg::reg_addr_t addr,
                                           core_pkg::data_t rf_data);
    if (addr == '0) return '0;
    if (ex_fwd_i.write_en && ex_fwd_i.write_addr == addr) return ex_fwd_i.value;
    if (mem_fwd_i.write_en && mem_fwd_i.write_addr == addr) return mem_fwd_i.value;
    return rf_data;
  endfunction

  assign op_1 = pick(rs, rf_rdata_1_i);
  assign op_2 = pick(rt, rf_rdata_2_i);

  always_comb begin
    dec                = '0;
    dec.alu_op         = core_pkg::ALU_ADD;
    dec.operand_1      = op_1;
    dec.operand_2      = op_2;
    dec.shamt          = inst[10:6];
    dec.mem_write_data = op_2;
    dec.pc             = if_id_i.pc;
    uses_rs            = 1'b0;
    uses_rt            = 1'b0;
    wr_en              = 1'b0;
    wr_addr            = rt;
    known_op           = 1'b1;
    case (opcode)
      core_pkg::OP_SPECIAL: begin
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        wr_en   = 1'b1;
        wr_addr = rd;
        case (funct)
          core_pkg::FN_ADDU: dec.alu_op = core_pkg::ALU_ADD;
          core_pkg::FN_SUBU: dec.alu_op = core_pkg::ALU_SUB;
          core_pkg::FN_AND:  dec.alu_op = core_pkg::ALU_AND;
          core_pkg::FN_OR:   dec.alu_op = core_pkg::ALU_OR;
          core_pkg::FN_XOR:  dec.alu_op = core_pkg::ALU_XOR;
          core_pkg::FN_SLT:  dec.alu_op = core_pkg::ALU_SLT;
          core_pkg::FN_SLL:  dec.alu_op = core_pkg::ALU_SLL;
          default:           wr_en = 1'b0;
        endcase
      end
      core_pkg::OP_ADDIU: begin
        uses_rs       = 1'b1;
        wr_en         = 1'b1;
        dec.operand_2 = imm_sext;
      end
      core_pkg::OP_ORI: begin
        uses_rs       = 1'b1;
        wr_en         = 1'b1;
        dec.alu_op    = core_pkg::ALU_OR;
        dec.operand_2 = imm_zext;
      end
      core_pkg::OP_LUI: begin
        wr_en         = 1'b1;
        dec.alu_op    = core_pkg::ALU_LUI;
        dec.operand_2 = imm_zext;
      end
      core_pkg::OP_LW: begin
        uses_rs       = 1'b1;
        wr_en         = 1'b1;
        dec.operand_2 = imm_sext;
        dec.mem_read  = 1'b1;
      end
      core_pkg::OP_SW: begin
        uses_rs       = 1'b1;
        uses_rt       = 1'b1;
        dec.operand_2 = imm_sext;
        dec.mem_write = 1'b1;
      end
      core_pkg::OP_BEQ, core_pkg::OP_BNE: begin
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      default: known_op = 1'b0;
    endcase
    // r0 is never a destination
    dec.reg_write_en   = wr_en && (wr_addr != '0);
    dec.reg_write_addr = wr_addr;
  end

  // Load result is not ready until the load leaves execute
  assign hazard_stall_o = ex_fwd_i.is_load && ex_fwd_i.write_en &&
                          ((uses_rs && ex_fwd_i.write_addr == rs) ||
                           (uses_rt && ex_fwd_i.write_addr == rt));

  assign branch_taken_o  = (opcode == core_pkg::OP_BEQ && op_1 == op_2) ||
                           (opcode == core_pkg::OP_BNE && op_1 != op_2);
  assign branch_target_o = if_id_i.pc + 32'd4 + {imm_sext[29:0], 2'b00};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_q <= '0;
    end else if (!freeze_i) begin
      id_ex_q <= hazard_stall_o ? '0 : dec;
    end
  end

  assign id_ex_o = id_ex_q;

  stall_bubble_a: assert property (@(posedge clk_i) disable iff (reset_i)
    hazard_stall_o && !freeze_i |=>
      !id_ex_o.reg_write_en && !id_ex_o.mem_read && !id_ex_o.mem_write);

  unknown_op_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !known_op && !freeze_i |=> !id_ex_o.mem_read && !id_ex_o.mem_write);

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               freeze_i,
  input  logic               hazard_stall_i,
  input  logic               branch_taken_i,
  input  core_pkg::data_t    branch_target_i,
  input  core_pkg::data_t    rom_data_i,
  output logic               rom_en_o,
  output core_pkg::data_t    rom_addr_o,
  output core_pkg::if_id_t   if_id_o
);

  core_pkg::data_t  pc_q;
  core_pkg::if_id_t if_id_q;
  logic             rom_en_q;
  logic             advance;

  assign advance = !freeze_i && !hazard_stall_i;

  // ROM comes up one cycle after reset, then stays on
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rom_en_q <= 1'b0;
      pc_q     <= core_pkg::RESET_PC;
      if_id_q  <= '0;
    end else if (advance) begin
      rom_en_q <= 1'b1;
      if (rom_en_q) begin
        pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
      end
      if_id_q.inst <= rom_en_q ? rom_data_i : '0;
      if_id_q.pc   <= pc_q;
    end
  end

  assign rom_en_o   = rom_en_q;
  assign rom_addr_o = pc_q;
  assign if_id_o    = if_id_q;

  pc_aligned_a: assert property (@(posedge clk_i) disable iff (reset_i)
    pc_q[1:0] == 2'b00);

endmodule

/* hw/core_pkg.sv */
package core_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [DATA_W-1:0] RESET_PC = 32'h0000_0000;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Primary opcode field, inst[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_e;

  // R-type function field, inst[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    data_t inst;
    data_t pc;
  } if_id_t;

  typedef struct packed {
    alu_op_e   alu_op;
    data_t     operand_1;
    data_t     operand_2;
    logic [4:0] shamt;
    logic      mem_read;
    logic      mem_write;
    data_t     mem_write_data;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    data_t     pc;
  } id_ex_t;

  typedef struct packed {
    data_t     result;
    logic      mem_read;
    logic      mem_write;
    data_t     mem_write_data;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    data_t     pc;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    data_t     write_data;
  } wb_write_t;

  // Result offered back to decode by a later stage
  typedef struct packed {
    logic      write_en;
    reg_addr_t write_addr;
    data_t     value;
    logic      is_load;
  } fwd_src_t;

endpackage
